//--- hw/stepper_config.svh
`ifndef STEPPER_CONFIG_SVH
`define STEPPER_CONFIG_SVH

// PWM resolution in bits
// 8-bit current drops its low bits to fit
`define CURRENT_BITS 7

// 1 brakes a bridge while its Vref is low
// 0 uses the brake setting alone
`define VREF_OFF_BRAKE 1

// Cycles between step strobes
`define STEP_GAP 4

`endif

//--- hw/stepper_pkg.sv
`default_nettype none

package stepper_pkg;

  // Host command opcodes, 3 bits on the wire
  typedef enum logic [2:0] {
    OP_NOP     = 3'd0, // No effect, acked at once
    OP_ENABLE  = 3'd1, // arg[0] drives the bridges
    OP_BRAKE   = 3'd2, // arg[0] shorts the coils while disabled
    OP_MODE    = 3'd3, // arg[2:0] microsteps, arg[3] dir
    OP_CURRENT = 3'd4, // arg[7:0] coil current
    OP_HOME    = 3'd5, // Phase counter back to origin
    OP_STEP    = 3'd6  // arg[7:0] step count
  } cmd_op_e;

  // Position within one electrical cycle
  // Eight positions, top two bits pick the quadrant
  typedef logic [2:0] phase_t;

  // Microstep mode
  // 0 full, 1 half, 2 quarter
  typedef logic [1:0] microstep_t;

endpackage

`default_nettype wire

//--- hw/hbridge_ctrl_if.sv
`default_nettype none

interface hbridge_ctrl_if
  import stepper_pkg::*;
();

  logic       enable;     // Bridges follow the phase pattern
  logic       brake;      // Coil short while disabled
  logic       dir;        // 1 counts up
  microstep_t microsteps; // Already clamped to 0..2
  logic [7:0] current;    // Full 8-bit setting
  logic       step_stb;   // One cycle per step
  logic       home_stb;   // One cycle, clears phase

  // Command side owns every field
  modport ctrl (
    output enable, brake, dir, microsteps, current,
    output step_stb, home_stb
  );

  // Bridge side only reads
  modport bridge (
    input enable, brake, dir, microsteps, current,
    input step_stb, home_stb
  );

endinterface

`default_nettype wire

//--- hw/pwm.sv
`default_nettype none

`include "stepper_config.svh"

module pwm #(
  parameter int bits = `CURRENT_BITS
) (
  input  logic            step,
  input  logic            rst_n,
  input  logic [bits-1:0] val,  // High cycles per period
  output logic            pwm
);

  // Free-running sawtooth
  // wraps every 2^bits cycles
  logic [bits-1:0] cnt;

  always_ff @(posedge step) begin
    if (!rst_n) begin
      cnt <= '0;
      pwm <= 1'b0;
    end else begin
      cnt <= cnt + 1'b1;  // Natural wrap
      pwm <= (cnt < val); // val of 0 keeps it low
    end
  end

  // Each counter value appears once per period
  // so any full window holds exactly val high cycles

endmodule

`default_nettype wire

//--- hw/motor_regs.sv
`default_nettype none

`include "stepper_config.svh"

module motor_regs
  import stepper_pkg::*;
(
  input  logic         step,
  input  logic         rst_n,
  input  logic         cmd_req,
  input  cmd_op_e      cmd_op,
  input  logic [7:0]   cmd_arg,
  output logic         cmd_ack,
  hbridge_ctrl_if.ctrl ctl
);

  // Gap timer wide enough for STEP_GAP - 1
  localparam int gap_w = $clog2(`STEP_GAP + 1);
  localparam logic [gap_w-1:0] gap_reload = gap_w'(`STEP_GAP - 1);

  typedef enum logic [1:0] {
    IDLE,     // Waiting for cmd_req
    STEPPING, // Emitting step strobes
    ACKED     // Ack high until req drops
  } state_e;

  state_e     state;
  logic [7:0] steps_left; // Strobes still to send
  logic [gap_w-1:0] gap_ct; // Cycles until next strobe
  microstep_t mode_clamped;
  logic       is_step;    // Non-zero STEP request

  // Modes 3..7 fall back to quarter step
  assign mode_clamped = (cmd_arg[2:0] > 3'd2) ? 2'd2 : cmd_arg[1:0];

  // A zero count behaves as a settings command
  assign is_step = (cmd_op == OP_STEP) && (cmd_arg != 8'd0);

  always_ff @(posedge step) begin
    if (!rst_n) begin
      state          <= IDLE;
      cmd_ack        <= 1'b0;
      steps_left     <= '0;
      gap_ct         <= '0;
      ctl.enable     <= 1'b0;
      ctl.brake      <= 1'b0;
      ctl.dir        <= 1'b0;
      ctl.microsteps <= '0;
      ctl.current    <= '0;
      ctl.step_stb   <= 1'b0;
      ctl.home_stb   <= 1'b0;
    end else begin
      // Strobes last one cycle
      ctl.step_stb <= 1'b0;
      ctl.home_stb <= 1'b0;

      case (state)
        IDLE: begin
          if (cmd_req) begin
            if (is_step) begin
              steps_left <= cmd_arg;
              gap_ct     <= '0; // First strobe on next edge
              state      <= STEPPING;
            end else begin
              // Settings land on the same edge as the ack
              cmd_ack <= 1'b1;
              state   <= ACKED;
              case (cmd_op)
                OP_ENABLE:  ctl.enable <= cmd_arg[0];
                OP_BRAKE:   ctl.brake  <= cmd_arg[0];
                OP_MODE: begin
                  ctl.microsteps <= mode_clamped;
                  ctl.dir        <= cmd_arg[3];
                end
                OP_CURRENT: ctl.current  <= cmd_arg;
                OP_HOME:    ctl.home_stb <= 1'b1;
                default: ; // NOP, zero-count STEP, spare code
              endcase
            end
          end
        end

        STEPPING: begin
          if (gap_ct == '0) begin
            ctl.step_stb <= 1'b1;
            steps_left   <= steps_left - 8'd1;
            gap_ct       <= gap_reload;
            // Ack rides on the last strobe
            if (steps_left == 8'd1) begin
              cmd_ack <= 1'b1;
              state   <= ACKED;
            end
          end else begin
            gap_ct <= gap_ct - 1'b1;
          end
        end

        ACKED: begin
          // Hold ack until the host lets go
          if (!cmd_req) begin
            cmd_ack <= 1'b0;
            state   <= IDLE;
          end
        end

        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/dual_hbridge.sv
`default_nettype none

`include "stepper_config.svh"

module dual_hbridge
  import stepper_pkg::*;
(
  input  logic           step,
  input  logic           rst_n,
  hbridge_ctrl_if.bridge ctl,
  output logic           phase_a1, // Bridge A high side
  output logic           phase_a2, // Bridge A low side
  output logic           phase_b1, // Bridge B high side
  output logic           phase_b2, // Bridge B low side
  output logic           vref_a,   // Current limit A
  output logic           vref_b    // Current limit B
);

  localparam logic vref_brake = 1'(`VREF_OFF_BRAKE);

  phase_t     phase_ct;   // Electrical position
  phase_t     abs_inc;    // 4, 2 or 1
  phase_t     phase_inc;  // Signed step as mod 8 value
  logic [3:0] polarity;   // a1 a2 b1 b2
  logic       brake_a;
  logic       brake_b;
  logic [`CURRENT_BITS-1:0] duty; // Current scaled to PWM width

  // Coarser modes jump further per step
  assign abs_inc   = 3'b100 >> ctl.microsteps;
  assign phase_inc = ctl.dir ? abs_inc : 3'd0 - abs_inc; // Backward wraps mod 8

  always_ff @(posedge step) begin
    if (!rst_n) begin
      phase_ct <= '0;
    end else if (ctl.home_stb) begin
      phase_ct <= '0; // Home wins over a step
    end else if (ctl.step_stb) begin
      phase_ct <= phase_ct + phase_inc;
    end
  end

  // Quadrant only
  // finer positions hold the pattern
  always_comb begin
    case (phase_ct[2:1])
      2'd0:    polarity = 4'b0101;
      2'd1:    polarity = 4'b0110;
      2'd2:    polarity = 4'b1010;
      default: polarity = 4'b1001;
    endcase
  end

  // Low Vref can also short the coil
  assign brake_a = ctl.brake | (vref_brake & ~vref_a);
  assign brake_b = ctl.brake | (vref_brake & ~vref_b);

  // Disabled bridge drives both legs alike
  assign phase_a1 = ctl.enable ? polarity[3] : brake_a;
  assign phase_a2 = ctl.enable ? polarity[2] : brake_a;
  assign phase_b1 = ctl.enable ? polarity[1] : brake_b;
  assign phase_b2 = ctl.enable ? polarity[0] : brake_b;

  // Top bits of the current setting
  assign duty = ctl.current[7 -: `CURRENT_BITS];

  // Same duty on both coils
  pwm #(
    .bits (`CURRENT_BITS)
  ) va (
    .step  (step),
    .rst_n (rst_n),
    .val   (duty),
    .pwm   (vref_a)
  );

  pwm #(
    .bits (`CURRENT_BITS)
  ) vb (
    .step  (step),
    .rst_n (rst_n),
    .val   (duty),
    .pwm   (vref_b)
  );

endmodule

`default_nettype wire

//--- hw/stepper_drive.sv
`default_nettype none

module stepper_drive
  import stepper_pkg::*;
(
  input  logic       step,
  input  logic       rst_n,
  // Host command port, four-phase req/ack
  input  logic       cmd_req,
  input  logic [2:0] cmd_op,
  input  logic [7:0] cmd_arg,
  output logic       cmd_ack,
  // Bridge pins
  output logic       phase_a1,
  output logic       phase_a2,
  output logic       phase_b1,
  output logic       phase_b2,
  output logic       vref_a,
  output logic       vref_b
);

  // Settings and strobes between the two blocks
  hbridge_ctrl_if ctl_if ();

  // Command decode and step pacing
  motor_regs u_regs (
    .step    (step),
    .rst_n   (rst_n),
    .cmd_req (cmd_req),
    .cmd_op  (cmd_op_e'(cmd_op)), // Raw bits to opcode
    .cmd_arg (cmd_arg),
    .cmd_ack (cmd_ack),
    .ctl     (ctl_if.ctrl)
  );

  // Phase counter and drivers
  dual_hbridge u_bridge (
    .step     (step),
    .rst_n    (rst_n),
    .ctl      (ctl_if.bridge),
    .phase_a1 (phase_a1),
    .phase_a2 (phase_a2),
    .phase_b1 (phase_b1),
    .phase_b2 (phase_b2),
    .vref_a   (vref_a),
    .vref_b   (vref_b)
  );

endmodule

`default_nettype wire

//--- test/stepper_drive_sva.sv
`default_nettype none

module stepper_drive_sva (
  input logic step,
  input logic rst_n,
  input logic cmd_req,
  input logic cmd_ack,
  input logic step_stb, // From the internal bridge link
  input logic enable,
  input logic phase_a1,
  input logic phase_a2,
  input logic phase_b1,
  input logic phase_b2
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [3:0] pat; // a1 a2 b1 b2

  assign pat = {phase_a1, phase_a2, phase_b1, phase_b2};

  // Ack only answers a pending request
  ack_needs_req: assert property (@(posedge step) disable iff (!rst_n)
    $rose(cmd_ack) |-> $past(cmd_req))
    else $error("cmd_ack rose with no request pending");

  // Release seen one edge later
  ack_release: assert property (@(posedge step) disable iff (!rst_n)
    $fell(cmd_req) && cmd_ack |=> $fell(cmd_ack))
    else $error("cmd_ack did not drop one cycle after cmd_req");

  // Strobes are paced
  stb_spacing: assert property (@(posedge step) disable iff (!rst_n)
    step_stb |=> !step_stb)
    else $error("step_stb high in two consecutive cycles");

  // Only the four quadrant patterns while driving
  legal_phase: assert property (@(posedge step) disable iff (!rst_n)
    enable |-> (pat inside {4'b0101, 4'b0110, 4'b1010, 4'b1001}))
    else $error("illegal phase pattern %b while enabled", pat);

endmodule

bind stepper_drive stepper_drive_sva sva_i (
  .step     (step),
  .rst_n    (rst_n),
  .cmd_req  (cmd_req),
  .cmd_ack  (cmd_ack),
  .step_stb (ctl_if.step_stb),
  .enable   (ctl_if.enable),
  .phase_a1 (phase_a1),
  .phase_a2 (phase_a2),
  .phase_b1 (phase_b1),
  .phase_b2 (phase_b2)
);

`default_nettype wire

//--- test/stepper_drive_tb.sv
`default_nettype none

`include "stepper_config.svh"

module stepper_drive_tb
  import stepper_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int max_vec = 64;
  localparam int period  = 20;
  localparam int window  = 1 << `CURRENT_BITS; // One full PWM period

  logic       step;
  logic       rst_n;
  logic       cmd_req;
  logic [2:0] cmd_op;
  logic [7:0] cmd_arg;
  logic       cmd_ack;
  logic       phase_a1, phase_a2, phase_b1, phase_b2;
  logic       vref_a, vref_b;

  logic [7:0] vec_mem [0:4*max_vec-1]; // op arg pat duty per vector
  int         n_vec;
  int         n_pass;
  int         n_fail;
  logic       loaded;

  // Reference model of the motor settings
  logic       m_en;
  logic       m_brake;
  logic       m_dir;
  int         m_ms;
  int         m_phase;
  logic [7:0] m_cur;

  stepper_drive uut (
    .step     (step),
    .rst_n    (rst_n),
    .cmd_req  (cmd_req),
    .cmd_op   (cmd_op),
    .cmd_arg  (cmd_arg),
    .cmd_ack  (cmd_ack),
    .phase_a1 (phase_a1),
    .phase_a2 (phase_a2),
    .phase_b1 (phase_b1),
    .phase_b2 (phase_b2),
    .vref_a   (vref_a),
    .vref_b   (vref_b)
  );

  initial begin
    step = 1'b0;
    forever #(period / 2) step = ~step;
  end

  task automatic check_val(input string name, input int exp_v, input int got_v);
    assert (exp_v == got_v) n_pass++;
    else begin
      $display("FAILED t=%0t signal=%s expected=%0h actual=%0h", $time, name, exp_v, got_v);
      n_fail++;
    end
  endtask

  // Quadrant of the 8-position cycle
  function automatic logic [3:0] quadrant_pattern(input int ph);
    case (ph)
      0, 1:    return 4'b0101;
      2, 3:    return 4'b0110;
      4, 5:    return 4'b1010;
      default: return 4'b1001;
    endcase
  endfunction

  function automatic int model_duty();
    return int'(m_cur) >> (8 - `CURRENT_BITS); // Drop low current bits
  endfunction

  // Negedges counted from driving req until ack is seen
  function automatic int ack_cycles(input logic [2:0] op, input logic [7:0] arg);
    if (op == OP_STEP && arg != 8'd0)
      return 3 + `STEP_GAP * (int'(arg) - 1); // Ack on the last strobe
    return 2; // One edge to sample and ack on it
  endfunction

  task automatic apply_model(input logic [2:0] op, input logic [7:0] arg);
    int inc;
    case (cmd_op_e'(op))
      OP_ENABLE:  m_en = arg[0];
      OP_BRAKE:   m_brake = arg[0];
      OP_MODE: begin
        m_ms  = (arg[2:0] > 3'd2) ? 2 : int'(arg[1:0]); // Clamp to quarter
        m_dir = arg[3];
      end
      OP_CURRENT: m_cur = arg;
      OP_HOME:    m_phase = 0;
      OP_STEP: begin
        inc = (m_ms == 0) ? 4 : (m_ms == 1) ? 2 : 1;
        if (!m_dir)
          inc = 8 - inc; // Backward as mod 8 step
        m_phase = (m_phase + inc * int'(arg)) % 8;
      end
      default: ;
    endcase
  endtask

  // dyn set when the outputs track the Vref pins
  task automatic predict(output logic [3:0] pat, output logic dyn);
    dyn = 1'b0;
    if (m_en) pat = quadrant_pattern(m_phase);
    else if (m_brake) pat = 4'hf;
    else if (`VREF_OFF_BRAKE == 0) pat = 4'h0;
    else if (model_duty() == 0) pat = 4'hf; // Vref never high
    else begin
      pat = 4'h0;
      dyn = 1'b1;
    end
  endtask

  // Four-phase handshake entered and left 1 ns after a rising edge
  task automatic run_command(input logic [2:0] op, input logic [7:0] arg,
                             output int lat, output int rel);
    cmd_op  = op;
    cmd_arg = arg;
    cmd_req = 1'b1;
    lat = 0;
    do begin
      @(negedge step);
      lat++;
    end while (!cmd_ack);
    @(posedge step);
    #1 cmd_req = 1'b0;
    rel = 0;
    do begin
      @(negedge step);
      rel++;
    end while (cmd_ack);
    @(posedge step);
    #1;
  endtask

  initial begin : watchdog
    longint limit;
    wait (loaded);
    limit = longint'(n_vec > 0 ? n_vec : 1) * (255 * `STEP_GAP + window + 50);
    #(limit * period);
    $display("Timeout: run still busy after %0d cycles", limit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin : main
    cmd_op_e    op;
    logic [7:0] arg;
    logic [7:0] want_pat;
    logic [7:0] want_duty;
    logic [3:0] mdl_pat;
    logic       mdl_dyn;
    int         v, lat, rel, hi_a, hi_b, fails_before;

    rst_n   = 1'b0;
    cmd_req = 1'b0;
    cmd_op  = 3'd0;
    cmd_arg = 8'd0;
    n_pass  = 0;
    n_fail  = 0;
    loaded  = 1'b0;
    m_en = 1'b0;
    m_brake = 1'b0;
    m_dir = 1'b0;
    m_ms = 0;
    m_phase = 0;
    m_cur = 8'd0;

    $readmemh("test/stepper_vectors.txt", vec_mem);
    n_vec = 0;
    while (n_vec < max_vec && vec_mem[4*n_vec] != 8'hff)
      n_vec++; // Stop at the end marker
    loaded = 1'b1;
    if (n_vec == 0) begin
      $display("No vectors found in test/stepper_vectors.txt");
      n_fail++;
    end

    repeat (2) @(posedge step);
    #1 rst_n = 1'b1;

    for (v = 0; v < n_vec; v++) begin
      op        = cmd_op_e'(vec_mem[4*v][2:0]);
      arg       = vec_mem[4*v+1];
      want_pat  = vec_mem[4*v+2];
      want_duty = vec_mem[4*v+3];
      fails_before = n_fail;

      run_command(op, arg, lat, rel);
      check_val("ack_latency", ack_cycles(op, arg), lat);
      check_val("ack_release", 2, rel);

      apply_model(op, arg);
      predict(mdl_pat, mdl_dyn);
      if (want_pat != 8'hff) begin
        if (mdl_dyn) begin
          $display("Vector %0d lists a fixed pattern but the model follows Vref", v);
          n_fail++;
        end else begin
          check_val("model_pattern", want_pat, mdl_pat);
        end
      end
      if (want_duty != 8'hff)
        check_val("model_duty", want_duty, model_duty());

      @(negedge step);
      if (!mdl_dyn)
        check_val("phase", mdl_pat, {phase_a1, phase_a2, phase_b1, phase_b2});

      // One PWM period for duty and Vref braking
      if (mdl_dyn || want_duty != 8'hff) begin
        hi_a = 0;
        hi_b = 0;
        repeat (window) begin
          @(negedge step);
          if (vref_a) hi_a++;
          if (vref_b) hi_b++;
          if (mdl_dyn)
            check_val("phase", {~vref_a, ~vref_a, ~vref_b, ~vref_b},
                      {phase_a1, phase_a2, phase_b1, phase_b2});
        end
        if (want_duty != 8'hff) begin
          check_val("vref_a_high", model_duty(), hi_a);
          check_val("vref_b_high", model_duty(), hi_b);
        end
      end

      @(posedge step);
      #1;
      $display("Vector %0d %s arg %02h: %s", v, op.name(), arg,
               (n_fail == fails_before) ? "ok" : "failed");
    end

    $display("Checks passed %0d failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+hw
hw/stepper_pkg.sv
hw/hbridge_ctrl_if.sv
hw/pwm.sv
hw/motor_regs.sv
hw/dual_hbridge.sv
hw/stepper_drive.sv
test/stepper_drive_sva.sv
test/stepper_drive_tb.sv

//--- Makefile
TOP = stepper_drive_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f files.f -o sim_bin
	./obj_dir/sim_bin | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/stepper_vectors.txt
// op arg pat duty, all hex, one host command per line
// pat is a1 a2 b1 b2 in the low nibble, ff in pat or duty skips that check
00 00 0f 00 // NOP after reset, braked, Vref idle
03 08 0f ff // Full step, dir up
01 01 05 ff // Enable at phase 0
06 01 0a ff // Full step jumps two quadrants
06 01 05 ff // Back to start
06 02 05 ff // Two full steps wrap
03 09 05 ff // Half step, dir up
06 01 06 ff
06 01 0a ff
06 01 09 ff
06 01 05 ff // Wrapped after four
03 0a 05 ff // Quarter step, dir up
06 01 05 ff // Same quadrant
06 01 06 ff
06 03 0a ff // Multi-step count
03 02 0a ff // Quarter step, dir down
06 01 0a ff
06 01 06 ff
03 07 06 ff // Mode 7 clamps to quarter
06 05 09 ff // Backward across zero
05 00 05 ff // Home
06 00 05 ff // Zero count acts as settings
04 80 05 40 // Half current
04 33 05 19
06 ff 05 19 // Longest step burst
01 00 ff 19 // Disabled, brake follows Vref
02 01 0f ff // Hard brake
04 ff 0f 7f // Full current
02 00 ff 7f // Brake off again
04 00 0f 00 // Vref idle brakes again
ff ff ff ff // End marker
